//--- design/cpu_settings.svh
// CPU ISA settings
// Fixed properties of the 16-bit load/store ISA shared by the
// pipeline control blocks. Register file size and the hardwired
// zero register live here.

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

////////////////////
// Register file
////////////////////
`define REG_ADDR_WIDTH 4   // Bits in a register index
`define NUM_REGS       16  // Architectural registers
`define ZERO_REG       0   // Reads as zero and drops writes

`endif

//--- design/isaPkg.sv
// ISA types
// Register index type and the decoded control bundle that the
// decoder hands to pipeline control for the instruction in ID.

`include "cpu_settings.svh"

package isaPkg;

  // One-nibble register index
  typedef logic [`REG_ADDR_WIDTH-1:0] regIdT;

  // Hardwired zero register
  localparam regIdT ZeroReg = regIdT'(`ZERO_REG);

  ////////////////////
  // Decoded control of the ID instruction
  ////////////////////
  typedef struct packed {
    regIdT srcReg1;    // Rs
    regIdT srcReg2;    // Rt or SW store data
    regIdT destReg;    // Rd
    logic  regWrite;   // Writes Rd in WB
    logic  memEnable;  // Data memory access
    logic  memWrite;   // Store when set with memEnable
    logic  zEn;        // Updates Z flag
    logic  nvEn;       // Updates N and V flags
    logic  branch;     // Any branch
    logic  br;         // Register-target branch
    logic  halt;       // HLT
  } decodeCtrlT;

endpackage

//--- design/pipeCtrlPkg.sv
// Pipeline control types
// Per-stage control bundle, hazard strobes, forward selects and the
// halt drain state. Also the register-hit check shared by the hazard
// and forwarding logic.

package pipeCtrlPkg;

  import isaPkg::*;

  // Control state held in one pipeline register
  typedef struct packed {
    regIdT destReg;
    logic  regWrite;
    logic  memEnable;
    logic  memWrite;
    logic  zEn;
    logic  nvEn;
    logic  halt;
    regIdT srcReg1;  // Operand A source for forwarding
    regIdT srcReg2;  // Operand B / store data source
  } stageCtrlT;

  localparam stageCtrlT StageBubble = '0;  // NOP with all enables low

  typedef struct packed {
    logic pcStall;    // Hold PC
    logic ifIdStall;  // Hold IF/ID
    logic idFlush;    // Bubble into ID/EX
    logic ifFlush;    // Kill IF/ID word on redirect
  } hazardCtrlT;

  ////////////////////
  // Forward selects
  ////////////////////
  typedef logic [1:0] fwdSelT;
  localparam fwdSelT FwdRegFile = 2'd0;  // No forwarding
  localparam fwdSelT FwdExMem   = 2'd1;  // From EX/MEM
  localparam fwdSelT FwdMemWb   = 2'd2;  // From MEM/WB

  typedef enum logic [1:0] {hsRunning, hsDraining, hsHalted} haltStateT;

  // Stage writes register r other than the zero register
  function automatic logic writesReg(stageCtrlT s, regIdT r);
    return s.regWrite && (s.destReg != ZeroReg) && (s.destReg == r);
  endfunction

endpackage

//--- design/hazardDetect.sv
// Hazard detection
// Finds load-to-use, B and BR hazards for the instruction in ID and
// turns them into the stall and flush strobes of the front end.
// PC is also held while a halt drains down the pipe.

module hazardDetect import isaPkg::*, pipeCtrlPkg::*; (
  input  decodeCtrlT idCtrl,      // Instruction in ID
  input  stageCtrlT  exStage,     // ID/EX control
  input  stageCtrlT  memStage,    // EX/MEM control
  input  logic       updatePc,    // Redirect from branch resolution
  input  logic       haltActive,  // Halt drain under way
  output hazardCtrlT hazard
);

  logic exIsLoad;     // LW sitting in EX
  logic exDestLive;   // EX Rd is not the zero register
  logic loadUseHaz;
  logic exSetsFlags;  // EX will update condition codes
  logic bHaz;
  logic brInst;
  logic brExHaz;      // Rs written by EX
  logic brMemHaz;     // Rs written by MEM
  logic brHaz;
  logic anyHaz;

  ////////////////////
  // Load-to-use
  ////////////////////
  assign exIsLoad   = exStage.memEnable & ~exStage.memWrite;
  assign exDestLive = (exStage.destReg != ZeroReg);

  // Store data on Rt comes over the MEM-to-MEM path, so no stall there
  assign loadUseHaz = exIsLoad & exDestLive &
                      ((exStage.destReg == idCtrl.srcReg1) |
                       ((exStage.destReg == idCtrl.srcReg2) &
                        ~(idCtrl.memEnable & idCtrl.memWrite)));

  ////////////////////
  // Branches
  ////////////////////
  assign exSetsFlags = exStage.zEn | exStage.nvEn;
  assign bHaz        = idCtrl.branch & exSetsFlags;  // Flags not ready yet

  assign brInst   = idCtrl.branch & idCtrl.br;
  assign brExHaz  = writesReg(exStage, idCtrl.srcReg1);
  assign brMemHaz = writesReg(memStage, idCtrl.srcReg1);

  // BR resolves in ID, so target register must be settled too
  assign brHaz = brInst & (exSetsFlags | brExHaz | brMemHaz);

  assign anyHaz = loadUseHaz | bHaz | brHaz;

  ////////////////////
  // Stalls and flushes
  ////////////////////
  always_comb begin
    hazard.ifIdStall = anyHaz;                // Hold decode
    hazard.idFlush   = anyHaz;                // NOP into EX
    hazard.pcStall   = anyHaz | haltActive;   // No fetch past a halt
    hazard.ifFlush   = updatePc & ~anyHaz;    // Squash wrong-path fetch
  end

endmodule

//--- design/stageCtrlRegs.sv
// Stage control registers
// Control state of the ID/EX, EX/MEM and MEM/WB pipeline registers.
// A flush from hazard detection loads a bubble into ID/EX. A small
// FSM follows a halt from EX down to WB and then holds the core.

module stageCtrlRegs import isaPkg::*, pipeCtrlPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  decodeCtrlT idCtrl,      // Decoded ID instruction
  input  logic       idFlush,     // Replace ID instruction by a NOP
  output stageCtrlT  exStage,     // ID/EX
  output stageCtrlT  memStage,    // EX/MEM
  output stageCtrlT  wbStage,     // MEM/WB
  output logic       haltActive,  // Drain or halted
  output logic       halted
);

  stageCtrlT idExNext;
  haltStateT haltState;
  haltStateT haltStateNext;

  // Keep only what later stages need
  function automatic stageCtrlT fromDecode(decodeCtrlT d);
    stageCtrlT s;
    s           = StageBubble;
    s.destReg   = d.destReg;
    s.regWrite  = d.regWrite;
    s.memEnable = d.memEnable;
    s.memWrite  = d.memWrite;
    s.zEn       = d.zEn;
    s.nvEn      = d.nvEn;
    s.halt      = d.halt;
    s.srcReg1   = d.srcReg1;
    s.srcReg2   = d.srcReg2;
    return s;
  endfunction

  assign idExNext = idFlush ? StageBubble : fromDecode(idCtrl);

  ////////////////////
  // Pipeline registers
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exStage  <= StageBubble;
      memStage <= StageBubble;
      wbStage  <= StageBubble;
    end else begin
      exStage  <= idExNext;
      memStage <= exStage;   // No back-pressure past ID
      wbStage  <= memStage;
    end
  end

  ////////////////////
  // Halt drain FSM
  ////////////////////
  always_comb begin
    haltStateNext = haltState;
    case (haltState)
      hsRunning:  if (exStage.halt) haltStateNext = hsDraining;   // Halt past ID
      hsDraining: if (memStage.halt) haltStateNext = hsHalted;    // Reaching WB
      hsHalted:   haltStateNext = hsHalted;                       // Until reset
      default:    haltStateNext = hsRunning;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      haltState <= hsRunning;
    end else begin
      haltState <= haltStateNext;
    end
  end

  assign haltActive = (haltState != hsRunning);
  assign halted     = (haltState == hsHalted);

  // Flushed slot shows up in EX without side effects
  assert property (@(posedge clk) disable iff (!arstN)
    idFlush |=> !exStage.regWrite && !exStage.memEnable)
    else $error("bubble in ID/EX carries regWrite or memEnable");

  // Halted is sticky
  assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
    else $error("halted dropped without reset");

  // Halt reaches WB on the same edge the FSM lands in halted
  assert property (@(posedge clk) disable iff (!arstN)
    $rose(halted) |-> wbStage.halt)
    else $error("halted raised before halt reached MEM/WB");

endmodule

//--- design/forwardUnit.sv
// Forwarding unit
// Picks the ALU operand sources for the instruction in EX and the
// store data source for a store in MEM. The nearer stage wins and
// the zero register never forwards.

`include "cpu_settings.svh"

module forwardUnit import isaPkg::*, pipeCtrlPkg::*; (
  input  stageCtrlT exStage,     // ID/EX operand consumer
  input  stageCtrlT memStage,    // EX/MEM nearest producer
  input  stageCtrlT wbStage,     // MEM/WB
  output fwdSelT    fwdA,        // Operand A source
  output fwdSelT    fwdB,        // Operand B source
  output logic      fwdMemData   // Store data from WB
);

  logic memIsStore;   // SW in MEM
  logic wbHitsData;   // WB writes the store data register

  // Register file must fill the index space
  if (`NUM_REGS != (1 << `REG_ADDR_WIDTH)) begin : gRegCountCheck
    $error("register count does not match register index width");
  end

  // Priority pick for one EX operand
  function automatic fwdSelT pickSource(regIdT src, stageCtrlT mem, stageCtrlT wb);
    fwdSelT sel;
    sel = FwdRegFile;
    if (writesReg(mem, src)) begin
      sel = FwdExMem;     // Most recent value
    end else if (writesReg(wb, src)) begin
      sel = FwdMemWb;
    end
    return sel;
  endfunction

  ////////////////////
  // EX operands
  ////////////////////
  assign fwdA = pickSource(exStage.srcReg1, memStage, wbStage);
  assign fwdB = pickSource(exStage.srcReg2, memStage, wbStage);

  ////////////////////
  // MEM-to-MEM
  ////////////////////
  assign memIsStore = memStage.memEnable & memStage.memWrite;
  assign wbHitsData = writesReg(wbStage, memStage.srcReg2);  // Load result into SW data
  assign fwdMemData = memIsStore & wbHitsData;

endmodule

//--- design/pipeControl.sv
// Pipeline control top
// Stage control registers, hazard detection and forwarding for the
// five-stage core. Takes the decoded ID instruction and the redirect
// strobe, returns stalls, flushes, forward selects and halted.

module pipeControl import isaPkg::*, pipeCtrlPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  decodeCtrlT idCtrl,      // From decode
  input  logic       updatePc,    // From branch resolution
  output hazardCtrlT hazard,
  output fwdSelT     fwdA,
  output fwdSelT     fwdB,
  output logic       fwdMemData,
  output logic       halted
);

  stageCtrlT exStage;     // ID/EX
  stageCtrlT memStage;    // EX/MEM
  stageCtrlT wbStage;     // MEM/WB
  logic      haltActive;

  ////////////////////
  // Control pipe
  ////////////////////
  stageCtrlRegs stageCtrlRegs_inst (
    .clk        (clk),
    .arstN      (arstN),
    .idCtrl     (idCtrl),
    .idFlush    (hazard.idFlush),
    .exStage    (exStage),
    .memStage   (memStage),
    .wbStage    (wbStage),
    .haltActive (haltActive),
    .halted     (halted)
  );

  hazardDetect hazardDetect_inst (
    .idCtrl     (idCtrl),
    .exStage    (exStage),
    .memStage   (memStage),
    .updatePc   (updatePc),
    .haltActive (haltActive),
    .hazard     (hazard)
  );

  forwardUnit forwardUnit_inst (
    .exStage    (exStage),
    .memStage   (memStage),
    .wbStage    (wbStage),
    .fwdA       (fwdA),
    .fwdB       (fwdB),
    .fwdMemData (fwdMemData)
  );

endmodule

//--- testbench/pipeControlTb.sv
// Pipeline control testbench
// Drives decoded instructions and redirects into pipeControl, keeps a
// shadow model of the three stage control registers and checks every
// DUT output against it with concurrent assertions.

module pipeControlTb import isaPkg::*, pipeCtrlPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HalfPeriod       = 4;
  localparam int ClkPeriod        = 2 * HalfPeriod;
  localparam int ResetCycles      = 4;
  localparam int IdleCycles       = 2;            // Quiet cycles after reset
  localparam int RandomCount      = 400;
  localparam int DirectedCount    = 30;           // Directed, halt and drain slots
  localparam int MaxCyclesPerInstr = 3;           // BR behind a writer stalls twice
  localparam int TestCycles       = ResetCycles + IdleCycles +
                                    (DirectedCount + RandomCount) * MaxCyclesPerInstr;
  localparam int WatchdogMargin   = 50 * ClkPeriod;

  logic       clk;
  logic       arstN;
  decodeCtrlT idCtrl;
  logic       updatePc;
  hazardCtrlT hazard;
  fwdSelT     fwdA;
  fwdSelT     fwdB;
  logic       fwdMemData;
  logic       halted;

  // Shadow pipeline
  stageCtrlT  modelEx;
  stageCtrlT  modelMem;
  stageCtrlT  modelWb;
  haltStateT  modelHalt;
  logic       lastStall;   // ID held at the last rising edge
  hazardCtrlT expHazard;
  fwdSelT     expFwdA;
  fwdSelT     expFwdB;
  logic       expFwdMemData;
  logic       loadUseExp;
  logic       bHazExp;
  logic       brHazExp;

  string testName;
  logic  postReset;        // Idle window before the first instruction
  int    hazardErrs, fwdErrs, haltErrs, resetErrs, reachErrs;
  int    loadUseSeen, bHazSeen, brHazSeen, memDataSeen, sameDestSeen;
  int    redirectStallSeen, haltedSeen;
  int    totalErrs;

  pipeControl pipeControl_inst (
    .clk        (clk),
    .arstN      (arstN),
    .idCtrl     (idCtrl),
    .updatePc   (updatePc),
    .hazard     (hazard),
    .fwdA       (fwdA),
    .fwdB       (fwdB),
    .fwdMemData (fwdMemData),
    .halted     (halted)
  );

  always #HalfPeriod clk = ~clk;

  ////////////////////
  // Reference rules
  ////////////////////
  function automatic logic producesReg(stageCtrlT s, regIdT r);
    return s.regWrite && (s.destReg != ZeroReg) && (s.destReg == r);
  endfunction

  // Nearer stage wins
  function automatic fwdSelT pickExpected(regIdT r, stageCtrlT mem, stageCtrlT wb);
    if (producesReg(mem, r)) return 2'd1;
    if (producesReg(wb, r)) return 2'd2;
    return 2'd0;
  endfunction

  function automatic stageCtrlT latchDecode(decodeCtrlT d);
    stageCtrlT s;
    s           = '0;
    s.destReg   = d.destReg;
    s.regWrite  = d.regWrite;
    s.memEnable = d.memEnable;
    s.memWrite  = d.memWrite;
    s.zEn       = d.zEn;
    s.nvEn      = d.nvEn;
    s.halt      = d.halt;
    s.srcReg1   = d.srcReg1;
    s.srcReg2   = d.srcReg2;
    return s;
  endfunction

  always_comb begin
    loadUseExp = modelEx.memEnable && !modelEx.memWrite && (modelEx.destReg != ZeroReg) &&
                 ((modelEx.destReg == idCtrl.srcReg1) ||
                  ((modelEx.destReg == idCtrl.srcReg2) &&
                   !(idCtrl.memEnable && idCtrl.memWrite)));   // Stores skip Rt
    bHazExp    = idCtrl.branch && (modelEx.zEn || modelEx.nvEn);
    brHazExp   = idCtrl.branch && idCtrl.br &&
                 (modelEx.zEn || modelEx.nvEn ||
                  producesReg(modelEx, idCtrl.srcReg1) || producesReg(modelMem, idCtrl.srcReg1));
    expHazard.ifIdStall = loadUseExp || bHazExp || brHazExp;
    expHazard.idFlush   = expHazard.ifIdStall;
    expHazard.pcStall   = expHazard.ifIdStall || (modelHalt != hsRunning);
    expHazard.ifFlush   = updatePc && !expHazard.ifIdStall;
    expFwdA       = pickExpected(modelEx.srcReg1, modelMem, modelWb);
    expFwdB       = pickExpected(modelEx.srcReg2, modelMem, modelWb);
    expFwdMemData = modelMem.memEnable && modelMem.memWrite &&
                    producesReg(modelWb, modelMem.srcReg2);
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      modelEx   <= '0;
      modelMem  <= '0;
      modelWb   <= '0;
      modelHalt <= hsRunning;
      lastStall <= 1'b0;
    end else begin
      modelEx   <= expHazard.idFlush ? '0 : latchDecode(idCtrl);  // Bubble on flush
      modelMem  <= modelEx;
      modelWb   <= modelMem;
      lastStall <= expHazard.ifIdStall;
      case (modelHalt)
        hsRunning:  if (modelEx.halt) modelHalt <= hsDraining;
        hsDraining: if (modelMem.halt) modelHalt <= hsHalted;    // Halt enters WB
        default:    modelHalt <= hsHalted;
      endcase
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  hazardCheck: assert property (@(posedge clk) disable iff (!arstN) hazard == expHazard)
    else begin
      hazardErrs++;
      $display("error %s hazard expected %b actual %b", testName,
               $sampled(expHazard), $sampled(hazard));
    end

  fwdACheck: assert property (@(posedge clk) disable iff (!arstN) fwdA == expFwdA)
    else begin
      fwdErrs++;
      $display("error %s fwdA expected %0d actual %0d", testName, $sampled(expFwdA), $sampled(fwdA));
    end

  fwdBCheck: assert property (@(posedge clk) disable iff (!arstN) fwdB == expFwdB)
    else begin
      fwdErrs++;
      $display("error %s fwdB expected %0d actual %0d", testName, $sampled(expFwdB), $sampled(fwdB));
    end

  memDataCheck: assert property (@(posedge clk) disable iff (!arstN)
    fwdMemData == expFwdMemData)
    else begin
      fwdErrs++;
      $display("error %s fwdMemData expected %b actual %b", testName,
               $sampled(expFwdMemData), $sampled(fwdMemData));
    end

  haltedCheck: assert property (@(posedge clk) disable iff (!arstN)
    halted == (modelHalt == hsHalted))
    else begin
      haltErrs++;
      $display("error %s halted expected %b actual %b", testName,
               $sampled(modelHalt == hsHalted), $sampled(halted));
    end

  // Redirect never squashes a held IF/ID word
  flushStallCheck: assert property (@(posedge clk) disable iff (!arstN)
    !(hazard.ifFlush && hazard.ifIdStall))
    else begin
      hazardErrs++;
      $display("ifFlush and ifIdStall were high together during %s", testName);
    end

  haltHoldCheck: assert property (@(posedge clk) disable iff (!arstN)
    (modelHalt != hsRunning) |-> hazard.pcStall)
    else begin
      haltErrs++;
      $display("pcStall dropped while a halt was draining or done");
    end

  haltedStickyCheck: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
    else begin
      haltErrs++;
      $display("halted fell back to 0 without a reset");
    end

  idleCheck: assert property (@(posedge clk) disable iff (!arstN)
    postReset |-> ({hazard, fwdA, fwdB, fwdMemData, halted} == '0))
    else begin
      resetErrs++;
      $display("error %s outputs expected %b actual %b", testName, 10'b0,
               $sampled({hazard, fwdA, fwdB, fwdMemData, halted}));
    end

  // Hit counts, so a check that never fired is noticed
  always @(posedge clk) begin
    if (arstN) begin
      if (loadUseExp) loadUseSeen++;
      if (bHazExp) bHazSeen++;
      if (brHazExp) brHazSeen++;
      if (expFwdMemData) memDataSeen++;
      if (expFwdA == 2'd1 && producesReg(modelWb, modelEx.srcReg1)) sameDestSeen++;
      if (updatePc && expHazard.ifIdStall) redirectStallSeen++;
      if (modelHalt == hsHalted) haltedSeen++;
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////
  function automatic decodeCtrlT aluOp(int dest, int src1, int src2, logic flags);
    decodeCtrlT d;
    d          = '0;
    d.destReg  = regIdT'(dest);
    d.srcReg1  = regIdT'(src1);
    d.srcReg2  = regIdT'(src2);
    d.regWrite = 1'b1;
    d.zEn      = flags;
    d.nvEn     = flags;
    return d;
  endfunction

  function automatic decodeCtrlT loadOp(int dest, int base);
    decodeCtrlT d;
    d           = '0;
    d.destReg   = regIdT'(dest);
    d.srcReg1   = regIdT'(base);
    d.regWrite  = 1'b1;
    d.memEnable = 1'b1;
    return d;
  endfunction

  function automatic decodeCtrlT storeOp(int base, int data);
    decodeCtrlT d;
    d           = '0;
    d.srcReg1   = regIdT'(base);
    d.srcReg2   = regIdT'(data);    // Store data on Rt
    d.memEnable = 1'b1;
    d.memWrite  = 1'b1;
    return d;
  endfunction

  function automatic decodeCtrlT branchOp(int target, logic isBr);
    decodeCtrlT d;
    d         = '0;
    d.srcReg1 = regIdT'(target);
    d.branch  = 1'b1;
    d.br      = isBr;
    return d;
  endfunction

  // Small register range so hazards and forwards are frequent
  function automatic decodeCtrlT randomInstr();
    int kind;
    kind = $urandom_range(5, 0);
    case (kind)
      0: return aluOp($urandom_range(3, 0), $urandom_range(3, 0), $urandom_range(3, 0),
                      $urandom_range(1, 0) == 1);
      1: return loadOp($urandom_range(3, 0), $urandom_range(3, 0));
      2: return storeOp($urandom_range(3, 0), $urandom_range(3, 0));
      3: return branchOp($urandom_range(3, 0), $urandom_range(1, 0) == 1);
      4: return aluOp($urandom_range(3, 0), $urandom_range(3, 0), $urandom_range(3, 0), 1'b0);
      default: return '0;   // NOP
    endcase
  endfunction

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic issueInstr(input decodeCtrlT instr, input logic redirect);
    idCtrl   = instr;
    updatePc = redirect;
    @(negedge clk);
    while (lastStall) @(negedge clk);   // Source holds ID steady while stalled
  endtask

  task automatic requireReached(input string what, input int hits);
    if (hits == 0) begin
      reachErrs++;
      $display("stimulus never reached the %s case", what);
    end
  endtask

  ////////////////////
  // Watchdog
  ////////////////////
  initial begin
    #(TestCycles * ClkPeriod + WatchdogMargin);
    $display("timeout, run did not finish within %0d cycles", TestCycles);
    $display("sim failed");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    void'($urandom(32'h883));
    clk       = 1'b0;
    arstN     = 1'b0;
    idCtrl    = '0;
    updatePc  = 1'b0;
    postReset = 1'b0;
    testName  = "reset";
    repeat (ResetCycles) @(negedge clk);
    arstN     = 1'b1;
    postReset = 1'b1;
    repeat (IdleCycles) @(negedge clk);
    postReset = 1'b0;

    testName = "loadUse";
    issueInstr(loadOp(1, 5), 1'b0);
    issueInstr(aluOp(2, 1, 3, 1'b0), 1'b0);   // One-cycle stall
    issueInstr(loadOp(4, 5), 1'b0);
    issueInstr(storeOp(6, 4), 1'b0);          // Rt only, MEM-to-MEM path
    issueInstr('0, 1'b0);
    issueInstr('0, 1'b0);

    testName = "bHazard";
    issueInstr(aluOp(6, 2, 3, 1'b1), 1'b0);
    issueInstr(branchOp(0, 1'b0), 1'b1);      // Redirect held through stall
    issueInstr('0, 1'b0);

    testName = "brHazard";
    issueInstr(aluOp(7, 2, 3, 1'b0), 1'b0);
    issueInstr(branchOp(7, 1'b1), 1'b1);      // Stalls in EX then MEM
    issueInstr(aluOp(0, 2, 3, 1'b0), 1'b0);
    issueInstr(branchOp(0, 1'b1), 1'b1);      // r0 never stalls
    issueInstr('0, 1'b0);
    issueInstr('0, 1'b0);

    testName = "random";
    repeat (RandomCount) issueInstr(randomInstr(), $urandom_range(3, 0) == 0);

    testName = "halt";
    repeat (3) issueInstr('0, 1'b0);
    issueInstr(decodeCtrlT'({$bits(decodeCtrlT){1'b0}} | 20'h1), 1'b0);  // halt bit only
    repeat (6) issueInstr('0, 1'b0);

    requireReached("load-to-use", loadUseSeen);
    requireReached("B hazard", bHazSeen);
    requireReached("BR hazard", brHazSeen);
    requireReached("store data forward", memDataSeen);
    requireReached("MEM and WB same destination", sameDestSeen);
    requireReached("redirect during stall", redirectStallSeen);
    requireReached("halted", haltedSeen);

    totalErrs = hazardErrs + fwdErrs + haltErrs + resetErrs + reachErrs;
    $display("errors hazard=%0d forward=%0d halt=%0d reset=%0d reach=%0d total=%0d",
             hazardErrs, fwdErrs, haltErrs, resetErrs, reachErrs, totalErrs);
    if (totalErrs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+design
design/isaPkg.sv
design/pipeCtrlPkg.sv
design/hazardDetect.sv
design/stageCtrlRegs.sv
design/forwardUnit.sv
design/pipeControl.sv
testbench/pipeControlTb.sv

//--- run.sh
#!/bin/sh
# Build and run the pipeline control testbench with Verilator.
# Pass or fail is read from the simulation log.
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert -f verilog.f \
  --top-module pipeControlTb -Mdir "$BUILD_DIR" -o pipeControlSim

"$BUILD_DIR/pipeControlSim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "sim failed" "$LOG"; then
  echo "FAIL: testbench reported failure"
  exit 1
fi
if ! grep -qx "sim passed" "$LOG"; then
  echo "FAIL: simulation ended without a result"
  exit 1
fi
echo "PASS"
